// File: source/decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int XLEN      = 32;
  localparam int REG_ID_W  = 4;
  localparam int NUM_REGS  = 16;
  localparam int PRED_ID_W = 2;
  localparam int NUM_PREDS = 4;
  localparam int IMM_W     = 23;

  typedef enum logic [5:0] {
    OP_NOP   = 6'h00, OP_NEG   = 6'h05, OP_NOT   = 6'h06, OP_AND    = 6'h07,
    OP_OR    = 6'h08, OP_XOR   = 6'h09, OP_ADD   = 6'h0a, OP_SUB    = 6'h0b,
    OP_MUL   = 6'h0c, OP_DIV   = 6'h0d, OP_MOD   = 6'h0e, OP_SHL    = 6'h0f,
    OP_SHR   = 6'h10, OP_ANDI  = 6'h11, OP_ORI   = 6'h12, OP_XORI   = 6'h13,
    OP_ADDI  = 6'h14, OP_SUBI  = 6'h15, OP_MULI  = 6'h16, OP_DIVI   = 6'h17,
    OP_MODI  = 6'h18, OP_SHLI  = 6'h19, OP_SHRI  = 6'h1a, OP_JALI   = 6'h1b,
    OP_JALR  = 6'h1c, OP_JMPI  = 6'h1d, OP_JMPR  = 6'h1e, OP_LD     = 6'h23,
    OP_ST    = 6'h24, OP_LDI   = 6'h25, OP_RTOP  = 6'h26, OP_ANDP   = 6'h27,
    OP_ORP   = 6'h28, OP_XORP  = 6'h29, OP_NOTP  = 6'h2a, OP_ISNEG  = 6'h2b,
    OP_ISZERO = 6'h2c, OP_ITOF = 6'h33, OP_FTOI  = 6'h34, OP_FADD   = 6'h35,
    OP_FSUB  = 6'h36, OP_FMUL  = 6'h37, OP_FDIV  = 6'h38, OP_FNEG   = 6'h39
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_NOP  = 4'h0, ALU_ADD  = 4'h1, ALU_SUB  = 4'h2, ALU_MUL  = 4'h3,
    ALU_DIV  = 4'h4, ALU_MOD  = 4'h5, ALU_SHL  = 4'h6, ALU_SHR  = 4'h7,
    ALU_AND  = 4'h8, ALU_OR   = 4'h9, ALU_XOR  = 4'ha, ALU_NEG  = 4'hb,
    ALU_NOT  = 4'hc, ALU_PASS = 4'hd, ALU_LINK = 4'he
  } alu_op_e;

  // predicate, test and float units reuse the integer code points
  localparam alu_op_e ALU_ANDP   = ALU_ADD;
  localparam alu_op_e ALU_ORP    = ALU_SUB;
  localparam alu_op_e ALU_XORP   = ALU_MUL;
  localparam alu_op_e ALU_NOTP   = ALU_DIV;
  localparam alu_op_e ALU_RTOP   = ALU_MOD;
  localparam alu_op_e ALU_ISNEG  = ALU_SHL;
  localparam alu_op_e ALU_ISZERO = ALU_SHR;
  localparam alu_op_e ALU_FCONV  = ALU_XOR;   // itof and fneg
  localparam alu_op_e ALU_FADD   = ALU_NEG;
  localparam alu_op_e ALU_FSUB   = ALU_NOT;
  localparam alu_op_e ALU_FMUL   = ALU_PASS;
  localparam alu_op_e ALU_FDIV   = ALU_LINK;

  typedef enum logic [1:0] {
    SEXT_NONE = 2'b00,
    SEXT_15   = 2'b01,
    SEXT_23   = 2'b10,
    SEXT_19   = 2'b11
  } sext_e;

  typedef struct packed {
    logic                 pset;
    logic [PRED_ID_W-1:0] pid;
    opcode_e              opcode;
    logic [REG_ID_W-1:0]  z;
    logic [REG_ID_W-1:0]  y;
    logic [REG_ID_W-1:0]  x;
    logic [10:0]          unused;
  } reg_fmt_t;

  typedef struct packed {
    logic                 pset;
    logic [PRED_ID_W-1:0] pid;
    opcode_e              opcode;
    logic [IMM_W-1:0]     imm;
  } imm_fmt_t;

  typedef union packed {
    reg_fmt_t reg_fmt;
    imm_fmt_t imm_fmt;
  } inst_t;

  typedef struct packed {
    logic    link;
    logic    src2_sel;
    alu_op_e alu_op;
    logic    imm_or_pf;
  } ex_ctrl_t;

  typedef struct packed {
    logic mem_write;
    logic mem_read;
  } mem_ctrl_t;

  typedef struct packed {
    logic wr_fpr;
    logic wr_gpr;
    logic wr_pred;
    logic reg_mem;   // result from memory
  } wb_ctrl_t;

  typedef struct packed {
    logic is_jump;
    logic rel_imm;
  } jmp_ctrl_t;

  typedef struct packed {
    logic has_ry;
    logic has_rx;
  } opc_type_t;

  typedef struct packed {
    opc_type_t opc_type;
    wb_ctrl_t  wb;
    mem_ctrl_t mem;
    ex_ctrl_t  ex;
    jmp_ctrl_t jmp;
    sext_e     sext;
    logic      x_sel;   // x index from z field
  } ctrl_t;

  typedef struct packed {
    logic                en;
    logic [REG_ID_W-1:0] id;
    logic [XLEN-1:0]     data;
  } reg_wr_t;

  typedef struct packed {
    logic                 en;
    logic [PRED_ID_W-1:0] id;
    logic                 val;
  } pred_wr_t;

  typedef struct packed {
    logic            px;
    logic            py;
    logic [XLEN-1:0] rx;
    logic [XLEN-1:0] ry;
    logic [XLEN-1:0] fx;
    logic [XLEN-1:0] fy;
  } operands_t;

  typedef logic [NUM_REGS-1:0][XLEN-1:0] reg_table_t;

  // entry 0 sits at the right end
  localparam reg_table_t GPR_INIT = {
    32'd15, 32'd14, 32'd13, 32'd12, 32'd11, 32'd10, 32'd9, 32'd8,
    32'd7,  32'd6,  32'd5,  32'd4,  32'd3,  32'd2,  32'd1, 32'd0
  };

  localparam reg_table_t FPR_INIT = {
    {12{32'h0}}, 32'h4080_0000, 32'h0, 32'h4040_0000, 32'h0
  };

  localparam logic [NUM_PREDS-1:0] PRED_INIT = 4'b0011;

endpackage

`default_nettype wire

// File: source/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_decoder
  import decode_pkg::*;
(
  input  opcode_e opcode,
  output ctrl_t   ctrl
);

  function automatic alu_op_e alu_of(input opcode_e op);
    case (op)
      OP_LD, OP_ST, OP_ADDI, OP_ADD: alu_of = ALU_ADD;
      OP_SUBI, OP_SUB:               alu_of = ALU_SUB;
      OP_MULI, OP_MUL:               alu_of = ALU_MUL;
      OP_DIVI, OP_DIV:               alu_of = ALU_DIV;
      OP_MODI, OP_MOD:               alu_of = ALU_MOD;
      OP_SHLI, OP_SHL:               alu_of = ALU_SHL;
      OP_SHRI, OP_SHR:               alu_of = ALU_SHR;
      OP_ANDI, OP_AND:               alu_of = ALU_AND;
      OP_ORI, OP_OR:                 alu_of = ALU_OR;
      OP_XORI, OP_XOR:               alu_of = ALU_XOR;
      OP_NEG:                        alu_of = ALU_NEG;
      OP_NOT:                        alu_of = ALU_NOT;
      OP_LDI:                        alu_of = ALU_PASS;
      OP_JALI, OP_JALR:              alu_of = ALU_LINK;
      OP_ANDP:                       alu_of = ALU_ANDP;
      OP_ORP:                        alu_of = ALU_ORP;
      OP_XORP:                       alu_of = ALU_XORP;
      OP_NOTP:                       alu_of = ALU_NOTP;
      OP_RTOP:                       alu_of = ALU_RTOP;
      OP_ISNEG:                      alu_of = ALU_ISNEG;
      OP_ISZERO:                     alu_of = ALU_ISZERO;
      OP_ITOF, OP_FNEG:              alu_of = ALU_FCONV;
      OP_FADD:                       alu_of = ALU_FADD;
      OP_FSUB:                       alu_of = ALU_FSUB;
      OP_FMUL:                       alu_of = ALU_FMUL;
      OP_FDIV:                       alu_of = ALU_FDIV;
      default:                       alu_of = ALU_NOP;
    endcase
  endfunction

  always_comb
  begin
    ctrl = '0;   // nop, ftoi and unknown codes stay here
    ctrl.ex.alu_op = alu_of(opcode);
    case (opcode)
      OP_LD:
      begin
        ctrl.opc_type.has_rx = 1'b1;
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.wb.reg_mem = 1'b1;
        ctrl.mem.mem_read = 1'b1;
        ctrl.ex.src2_sel = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.sext = SEXT_15;
      end
      OP_ST:
      begin
        ctrl.opc_type = '{has_ry: 1'b1, has_rx: 1'b1};
        ctrl.mem.mem_write = 1'b1;
        ctrl.ex.src2_sel = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.sext = SEXT_15;
        ctrl.x_sel = 1'b1;   // store data reg sits in z
      end
      OP_ANDP, OP_ORP, OP_XORP, OP_NOTP:
      begin
        ctrl.wb.wr_pred = 1'b1;
      end
      OP_RTOP, OP_ISNEG, OP_ISZERO:
      begin
        ctrl.opc_type.has_rx = 1'b1;
        ctrl.wb.wr_pred = 1'b1;
      end
      OP_LDI:
      begin
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.ex.src2_sel = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.sext = SEXT_19;
      end
      OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI,
      OP_SHLI, OP_SHRI, OP_ANDI, OP_ORI, OP_XORI:
      begin
        ctrl.opc_type.has_rx = 1'b1;
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.ex.src2_sel = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.sext = SEXT_15;
      end
      OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD,
      OP_SHL, OP_SHR, OP_AND, OP_OR, OP_XOR:
      begin
        ctrl.opc_type = '{has_ry: 1'b1, has_rx: 1'b1};
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
      end
      OP_NEG, OP_NOT:
      begin
        ctrl.opc_type.has_rx = 1'b1;   // unary, no y
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
      end
      OP_ITOF, OP_FNEG, OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV:
      begin
        ctrl.wb.wr_fpr = 1'b1;
        ctrl.x_sel = 1'b1;
      end
      OP_JMPI:
      begin
        ctrl.jmp = '{is_jump: 1'b1, rel_imm: 1'b1};
        ctrl.sext = SEXT_23;
      end
      OP_JMPR:
      begin
        ctrl.opc_type.has_ry = 1'b1;
        ctrl.jmp.rel_imm = 1'b1;
        ctrl.x_sel = 1'b1;
      end
      OP_JALI:
      begin
        ctrl.wb.wr_gpr = 1'b1;
        ctrl.ex.link = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.jmp = '{is_jump: 1'b1, rel_imm: 1'b1};
        ctrl.sext = SEXT_19;
      end
      OP_JALR:
      begin
        ctrl.opc_type.has_ry = 1'b1;
        ctrl.wb.wr_gpr = 1'b1;   // return address
        ctrl.ex.link = 1'b1;
        ctrl.ex.imm_or_pf = 1'b1;
        ctrl.jmp.rel_imm = 1'b1;
      end
      default:
      begin
        ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank
  import decode_pkg::*;
#(
  parameter int                        NUM  = NUM_REGS,
  parameter logic [NUM-1:0][XLEN-1:0] INIT = '0
) (
  input  logic                clk,
  input  logic                rst,
  input  reg_wr_t             wr,
  input  logic [REG_ID_W-1:0] x_id,
  input  logic [REG_ID_W-1:0] y_id,
  output logic [XLEN-1:0]     x_data,
  output logic [XLEN-1:0]     y_data
);

  logic [NUM-1:0][XLEN-1:0] regs;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      regs <= INIT;
    end
    else if (wr.en)
    begin
      regs[wr.id] <= wr.data;
    end
  end

  // no bypass, a same-cycle write shows up next cycle
  assign x_data = regs[x_id];
  assign y_data = regs[y_id];

endmodule

`default_nettype wire

// File: source/pred_file.sv
`timescale 1ns/1ps
`default_nettype none

module pred_file
  import decode_pkg::*;
#(
  parameter int             NUM  = NUM_PREDS,
  parameter logic [NUM-1:0] INIT = PRED_INIT
) (
  input  logic                 clk,
  input  logic                 rst,
  input  pred_wr_t             wr,
  input  logic [PRED_ID_W-1:0] x_id,
  input  logic [PRED_ID_W-1:0] y_id,
  input  logic                 pset,
  input  logic [PRED_ID_W-1:0] pid,
  output logic                 px,
  output logic                 py,
  output logic                 pval
);

  logic [NUM-1:0] preds;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      preds <= INIT;
    end
    else if (wr.en)
    begin
      preds[wr.id] <= wr.val;
    end
  end

  assign px = preds[x_id];
  assign py = preds[y_id];
  assign pval = pset ? preds[pid] : 1'b1;   // unguarded always runs

endmodule

`default_nettype wire

// File: source/imm_unit.sv
`timescale 1ns/1ps
`default_nettype none

module imm_unit
  import decode_pkg::*;
#(
  parameter int W = XLEN
) (
  input  sext_e            sext,
  input  logic [IMM_W-1:0] field,
  input  logic [W-1:0]     pc_n,
  output logic [W-1:0]     imm,
  output logic [W-1:0]     jmp_target
);

  always_comb
  begin
    case (sext)
      SEXT_15: imm = {{(W-15){field[14]}}, field[14:0]};
      SEXT_23: imm = {{(W-23){field[22]}}, field[22:0]};
      SEXT_19: imm = {{(W-19){field[18]}}, field[18:0]};
      default: imm = '0;
    endcase
  end

  // relative to the next pc, wraps around
  assign jmp_target = pc_n + imm;

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import decode_pkg::*;
#(
  parameter int                           N_REGS   = NUM_REGS,
  parameter logic [N_REGS-1:0][XLEN-1:0] GPR_RST  = GPR_INIT,
  parameter logic [N_REGS-1:0][XLEN-1:0] FPR_RST  = FPR_INIT,
  parameter logic [NUM_PREDS-1:0]        PRED_RST = PRED_INIT
) (
  input  logic                clk,
  input  logic                rst,
  input  inst_t               inst,
  input  logic [XLEN-1:0]     pc_n,
  input  reg_wr_t             gpr_wr,
  input  reg_wr_t             fpr_wr,
  input  pred_wr_t            pred_wr,
  output ctrl_t               ctrl,
  output operands_t           ops,
  output logic [XLEN-1:0]     imm,
  output logic [XLEN-1:0]     jmp_target,
  output logic [REG_ID_W-1:0] x_id,
  output logic [REG_ID_W-1:0] y_id,
  output logic [REG_ID_W-1:0] z_id,
  output logic                pval
);

  logic            px;
  logic            py;
  logic [XLEN-1:0] rx;
  logic [XLEN-1:0] ry;
  logic [XLEN-1:0] fx;
  logic [XLEN-1:0] fy;

  assign z_id = inst.reg_fmt.z;
  assign y_id = inst.reg_fmt.y;
  assign x_id = ctrl.x_sel ? inst.reg_fmt.z : inst.reg_fmt.x;

  op_decoder u_op_decoder (
    .opcode (inst.reg_fmt.opcode),
    .ctrl   (ctrl)
  );

  reg_bank #(
    .NUM  (N_REGS),
    .INIT (GPR_RST)
  ) gprs (
    .clk    (clk),
    .rst    (rst),
    .wr     (gpr_wr),
    .x_id   (x_id),
    .y_id   (y_id),
    .x_data (rx),
    .y_data (ry)
  );

  reg_bank #(
    .NUM  (N_REGS),
    .INIT (FPR_RST)
  ) fprs (
    .clk    (clk),
    .rst    (rst),
    .wr     (fpr_wr),
    .x_id   (x_id),
    .y_id   (y_id),
    .x_data (fx),
    .y_data (fy)
  );

  pred_file #(
    .NUM  (NUM_PREDS),
    .INIT (PRED_RST)
  ) u_pred_file (
    .clk  (clk),
    .rst  (rst),
    .wr   (pred_wr),
    .x_id (x_id[PRED_ID_W-1:0]),   // low bits only
    .y_id (y_id[PRED_ID_W-1:0]),
    .pset (inst.reg_fmt.pset),
    .pid  (inst.reg_fmt.pid),
    .px   (px),
    .py   (py),
    .pval (pval)
  );

  imm_unit #(
    .W (XLEN)
  ) u_imm_unit (
    .sext       (ctrl.sext),
    .field      (inst.imm_fmt.imm),
    .pc_n       (pc_n),
    .imm        (imm),
    .jmp_target (jmp_target)
  );

  assign ops = '{px: px, py: py, rx: rx, ry: ry, fx: fx, fy: fy};

endmodule

`default_nettype wire

// File: bench/decode_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_sva
  import decode_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic [XLEN-1:0]     pc_n,
  input reg_wr_t             gpr_wr,
  input reg_wr_t             fpr_wr,
  input ctrl_t               ctrl,
  input operands_t           ops,
  input logic [XLEN-1:0]     imm,
  input logic [XLEN-1:0]     jmp_target,
  input logic [REG_ID_W-1:0] x_id
);

  mem_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.mem.mem_read && ctrl.mem.mem_write))
    else $error("mem_read and mem_write both high");

  target_sum: assert property (@(posedge clk) disable iff (rst)
    jmp_target == pc_n + imm)
    else $error("jmp_target differs from pc_n plus imm");

  // written value visible one cycle later on the x port
  gpr_write_seen: assert property (@(posedge clk) disable iff (rst)
    gpr_wr.en ##1 (!gpr_wr.en && x_id == $past(gpr_wr.id)) |-> ops.rx == $past(gpr_wr.data))
    else $error("general register write not visible on rx");

  fpr_write_seen: assert property (@(posedge clk) disable iff (rst)
    fpr_wr.en ##1 (!fpr_wr.en && x_id == $past(fpr_wr.id)) |-> ops.fx == $past(fpr_wr.data))
    else $error("floating register write not visible on fx");

endmodule

bind decode_stage decode_stage_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .pc_n       (pc_n),
  .gpr_wr     (gpr_wr),
  .fpr_wr     (fpr_wr),
  .ctrl       (ctrl),
  .ops        (ops),
  .imm        (imm),
  .jmp_target (jmp_target),
  .x_id       (x_id)
);

`default_nettype wire

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
  import decode_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int WATCHDOG_CYCLES = 3000;   // tests need about 300

  logic                clk;
  logic                rst;
  inst_t               inst;
  logic [XLEN-1:0]     pc_n;
  reg_wr_t             gpr_wr;
  reg_wr_t             fpr_wr;
  pred_wr_t            pred_wr;
  ctrl_t               ctrl;
  operands_t           ops;
  logic [XLEN-1:0]     imm;
  logic [XLEN-1:0]     jmp_target;
  logic [REG_ID_W-1:0] x_id;
  logic [REG_ID_W-1:0] y_id;
  logic [REG_ID_W-1:0] z_id;
  logic                pval;

  int          errors;
  int          checks;
  logic [XLEN-1:0] gpr_model [NUM_REGS];
  logic [XLEN-1:0] fpr_model [NUM_REGS];
  logic            pred_model [NUM_PREDS];

  decode_stage dut (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .pc_n       (pc_n),
    .gpr_wr     (gpr_wr),
    .fpr_wr     (fpr_wr),
    .pred_wr    (pred_wr),
    .ctrl       (ctrl),
    .ops        (ops),
    .imm        (imm),
    .jmp_target (jmp_target),
    .x_id       (x_id),
    .y_id       (y_id),
    .z_id       (z_id),
    .pval       (pval)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic wait_drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_sample_slot();
    @(negedge clk);
  endtask

  task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic inst_t reg_inst(input opcode_e op, input logic [REG_ID_W-1:0] z,
                                     input logic [REG_ID_W-1:0] y,
                                     input logic [REG_ID_W-1:0] x);
    inst_t w;
    w = '0;
    w.reg_fmt.opcode = op;
    w.reg_fmt.z = z;
    w.reg_fmt.y = y;
    w.reg_fmt.x = x;
    return w;
  endfunction

  function automatic inst_t imm_inst(input opcode_e op, input logic [IMM_W-1:0] field);
    inst_t w;
    w = '0;
    w.imm_fmt.opcode = op;
    w.imm_fmt.imm = field;
    return w;
  endfunction

  // shift the field to the top, then arithmetic shift back down
  function automatic logic [XLEN-1:0] extend(input logic [IMM_W-1:0] field, input int bits);
    logic [XLEN-1:0] v;
    if (bits == 0)
      return '0;
    v = XLEN'(field) << (XLEN - bits);
    return $signed(v) >>> (XLEN - bits);
  endfunction

  // expected control word, built column by column from the group rules
  function automatic ctrl_t expected_ctrl(input opcode_e op);
    ctrl_t c;
    logic is_ld, is_st, is_ldi, is_pl, is_test, is_immop, is_regop, is_unary;
    logic is_fp, is_jmpi, is_jmpr, is_jali, is_jalr;
    is_ld = (op == OP_LD);
    is_st = (op == OP_ST);
    is_ldi = (op == OP_LDI);
    is_pl = op inside {OP_ANDP, OP_ORP, OP_XORP, OP_NOTP};
    is_test = op inside {OP_RTOP, OP_ISNEG, OP_ISZERO};
    is_immop = op inside {OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI,
                          OP_SHLI, OP_SHRI, OP_ANDI, OP_ORI, OP_XORI};
    is_regop = op inside {OP_ADD, OP_SUB, OP_MUL, OP_DIV, OP_MOD,
                          OP_SHL, OP_SHR, OP_AND, OP_OR, OP_XOR};
    is_unary = op inside {OP_NEG, OP_NOT};
    is_fp = op inside {OP_ITOF, OP_FNEG, OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV};
    is_jmpi = (op == OP_JMPI);
    is_jmpr = (op == OP_JMPR);
    is_jali = (op == OP_JALI);
    is_jalr = (op == OP_JALR);
    c = '0;
    c.opc_type.has_rx = is_ld | is_st | is_test | is_immop | is_regop | is_unary;
    c.opc_type.has_ry = is_st | is_regop | is_jmpr | is_jalr;
    c.wb.reg_mem = is_ld;
    c.wb.wr_pred = is_pl | is_test;
    c.wb.wr_gpr = is_ld | is_ldi | is_immop | is_regop | is_unary | is_jali | is_jalr;
    c.wb.wr_fpr = is_fp;
    c.mem.mem_read = is_ld;
    c.mem.mem_write = is_st;
    c.ex.link = is_jali | is_jalr;
    c.ex.src2_sel = is_ld | is_st | is_ldi | is_immop;
    c.ex.imm_or_pf = c.ex.src2_sel | is_regop | is_unary | is_jali | is_jalr;
    c.jmp.is_jump = is_jmpi | is_jali;
    c.jmp.rel_imm = is_jmpi | is_jmpr | is_jali | is_jalr;
    c.x_sel = is_st | is_fp | is_jmpr;
    if (is_ld | is_st | is_immop)
      c.sext = SEXT_15;
    else if (is_ldi | is_jali)
      c.sext = SEXT_19;
    else if (is_jmpi)
      c.sext = SEXT_23;
    case (op)
      OP_LD, OP_ST, OP_ADD, OP_ADDI: c.ex.alu_op = ALU_ADD;
      OP_SUB, OP_SUBI:               c.ex.alu_op = ALU_SUB;
      OP_MUL, OP_MULI:               c.ex.alu_op = ALU_MUL;
      OP_DIV, OP_DIVI:               c.ex.alu_op = ALU_DIV;
      OP_MOD, OP_MODI:               c.ex.alu_op = ALU_MOD;
      OP_SHL, OP_SHLI:               c.ex.alu_op = ALU_SHL;
      OP_SHR, OP_SHRI:               c.ex.alu_op = ALU_SHR;
      OP_AND, OP_ANDI:               c.ex.alu_op = ALU_AND;
      OP_OR, OP_ORI:                 c.ex.alu_op = ALU_OR;
      OP_XOR, OP_XORI:               c.ex.alu_op = ALU_XOR;
      OP_NEG:                        c.ex.alu_op = ALU_NEG;
      OP_NOT:                        c.ex.alu_op = ALU_NOT;
      OP_LDI:                        c.ex.alu_op = ALU_PASS;
      OP_JALI, OP_JALR:              c.ex.alu_op = ALU_LINK;
      OP_ANDP:                       c.ex.alu_op = ALU_ANDP;
      OP_ORP:                        c.ex.alu_op = ALU_ORP;
      OP_XORP:                       c.ex.alu_op = ALU_XORP;
      OP_NOTP:                       c.ex.alu_op = ALU_NOTP;
      OP_RTOP:                       c.ex.alu_op = ALU_RTOP;
      OP_ISNEG:                      c.ex.alu_op = ALU_ISNEG;
      OP_ISZERO:                     c.ex.alu_op = ALU_ISZERO;
      OP_ITOF, OP_FNEG:              c.ex.alu_op = ALU_FCONV;
      OP_FADD:                       c.ex.alu_op = ALU_FADD;
      OP_FSUB:                       c.ex.alu_op = ALU_FSUB;
      OP_FMUL:                       c.ex.alu_op = ALU_FMUL;
      OP_FDIV:                       c.ex.alu_op = ALU_FDIV;
      default:                       c.ex.alu_op = ALU_NOP;
    endcase
    return c;
  endfunction

  task automatic load_reset_model();
    for (int i = 0; i < NUM_REGS; i++)
    begin
      gpr_model[i] = XLEN'(i);
      fpr_model[i] = (i == 1) ? 32'h4040_0000 : (i == 3) ? 32'h4080_0000 : 32'h0;
    end
    for (int i = 0; i < NUM_PREDS; i++)
      pred_model[i] = (i < 2);   // 1, 1, 0, 0
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < NUM_REGS; i++)
    begin
      wait_drive_slot();
      inst = reg_inst(OP_ADD, 4'd0, REG_ID_W'(i), REG_ID_W'(i));
      wait_sample_slot();
      check_word($sformatf("rx[%0d]", i), ops.rx, gpr_model[i]);
      check_word($sformatf("ry[%0d]", i), ops.ry, gpr_model[i]);
      check_word($sformatf("fx[%0d]", i), ops.fx, fpr_model[i]);
      check_word($sformatf("fy[%0d]", i), ops.fy, fpr_model[i]);
      if (i < NUM_PREDS)
      begin
        check_bit($sformatf("px[%0d]", i), ops.px, pred_model[i]);
        check_bit($sformatf("py[%0d]", i), ops.py, pred_model[i]);
      end
    end
  endtask

  task automatic test_ctrl_table();
    for (int i = 0; i < 64; i++)
    begin
      wait_drive_slot();
      inst = reg_inst(opcode_e'(6'(i)), REG_ID_W'($urandom), REG_ID_W'($urandom),
                      REG_ID_W'($urandom));
      wait_sample_slot();
      check_ctrl($sformatf("ctrl op 0x%02h", i), ctrl, expected_ctrl(opcode_e'(6'(i))));
    end
  endtask

  task automatic test_immediates();
    opcode_e          kind_op [4] = '{OP_ADD, OP_ADDI, OP_JMPI, OP_LDI};
    int               kind_bits [4] = '{0, 15, 23, 19};
    logic [IMM_W-1:0] field;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  exp_imm;
    for (int k = 0; k < 4; k++)
    begin
      for (int n = 0; n < 16; n++)
      begin
        field = (n == 0) ? '1 : (n == 1) ? '0 : IMM_W'($urandom);
        pc = $urandom;
        exp_imm = extend(field, kind_bits[k]);
        wait_drive_slot();
        inst = imm_inst(kind_op[k], field);
        pc_n = pc;
        wait_sample_slot();
        check_word($sformatf("imm sext%0d", kind_bits[k]), imm, exp_imm);
        check_word($sformatf("jmp_target sext%0d", kind_bits[k]), jmp_target, pc + exp_imm);
      end
    end
  endtask

  task automatic test_write_back();
    logic [REG_ID_W-1:0] id;
    logic [REG_ID_W-1:0] other;
    logic [XLEN-1:0]     data;
    logic                use_fpr;
    for (int n = 0; n < 24; n++)
    begin
      id = REG_ID_W'($urandom);
      other = REG_ID_W'($urandom);
      data = $urandom;
      use_fpr = (n % 2 == 1);
      wait_drive_slot();
      if (use_fpr)
      begin
        fpr_wr = '{en: 1'b1, id: id, data: data};
        inst = reg_inst(OP_FADD, id, id, other);   // x index comes from z
      end
      else
      begin
        gpr_wr = '{en: 1'b1, id: id, data: data};
        inst = reg_inst(OP_ADD, other, id, id);
      end
      wait_sample_slot();
      if (use_fpr)
        check_word("fx before edge", ops.fx, fpr_model[id]);
      else
        check_word("rx before edge", ops.rx, gpr_model[id]);
      if (use_fpr)
        fpr_model[id] = data;
      else
        gpr_model[id] = data;
      wait_drive_slot();
      gpr_wr.en = 1'b0;
      fpr_wr.en = 1'b0;
      wait_sample_slot();
      check_word($sformatf("fx[%0d]", id), ops.fx, fpr_model[id]);
      check_word($sformatf("fy[%0d]", id), ops.fy, fpr_model[id]);
      check_word($sformatf("rx[%0d]", id), ops.rx, gpr_model[id]);
      check_word($sformatf("ry[%0d]", id), ops.ry, gpr_model[id]);
    end
    // writes while rst is high must be dropped
    wait_drive_slot();
    rst = 1'b1;
    gpr_wr = '{en: 1'b1, id: 4'd5, data: $urandom};
    fpr_wr = '{en: 1'b1, id: 4'd1, data: $urandom};
    pred_wr = '{en: 1'b1, id: 2'd2, val: 1'b1};
    repeat (3) wait_drive_slot();
    rst = 1'b0;
    gpr_wr.en = 1'b0;
    fpr_wr.en = 1'b0;
    pred_wr.en = 1'b0;
    load_reset_model();
    test_reset_values();
  endtask

  task automatic test_pred_guard();
    logic [PRED_ID_W-1:0] p;
    logic                 v;
    for (int n = 0; n < 12; n++)
    begin
      p = PRED_ID_W'($urandom);
      v = 1'($urandom);
      wait_drive_slot();
      pred_wr = '{en: 1'b1, id: p, val: v};
      pred_model[p] = v;
      for (int g = 0; g < NUM_PREDS; g++)
      begin
        wait_drive_slot();
        pred_wr.en = 1'b0;
        inst = reg_inst(OP_ANDP, 4'd0, REG_ID_W'(g), REG_ID_W'(g));
        inst.reg_fmt.pset = 1'b1;
        inst.reg_fmt.pid = PRED_ID_W'(g);
        wait_sample_slot();
        check_bit($sformatf("pval guarded by p%0d", g), pval, pred_model[g]);
        check_bit($sformatf("px[%0d]", g), ops.px, pred_model[g]);
        check_bit($sformatf("py[%0d]", g), ops.py, pred_model[g]);
      end
      wait_drive_slot();
      inst.reg_fmt.pset = 1'b0;
      inst.reg_fmt.pid = PRED_ID_W'($urandom);
      wait_sample_slot();
      check_bit("pval unguarded", pval, 1'b1);
    end
  endtask

  task automatic test_operand_select();
    logic [REG_ID_W-1:0] z;
    logic [REG_ID_W-1:0] y;
    logic [REG_ID_W-1:0] x;
    for (int n = 0; n < 8; n++)
    begin
      z = REG_ID_W'($urandom);
      y = REG_ID_W'($urandom);
      x = REG_ID_W'($urandom);
      wait_drive_slot();
      inst = reg_inst(OP_ST, z, y, x);
      wait_sample_slot();
      check_word("x_id for st", XLEN'(x_id), XLEN'(z));
      check_word("y_id for st", XLEN'(y_id), XLEN'(y));
      check_word("z_id for st", XLEN'(z_id), XLEN'(z));
      wait_drive_slot();
      inst = reg_inst(OP_ADD, z, y, x);
      wait_sample_slot();
      check_word("x_id for add", XLEN'(x_id), XLEN'(x));
      check_word("y_id for add", XLEN'(y_id), XLEN'(y));
    end
  endtask

  initial
  begin
    void'($urandom(78));
    errors = 0;
    checks = 0;
    rst = 1'b1;
    inst = '0;
    pc_n = '0;
    gpr_wr = '0;
    fpr_wr = '0;
    pred_wr = '0;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    load_reset_model();
    test_reset_values();
    test_ctrl_table();
    test_immediates();
    test_write_back();
    test_pred_guard();
    test_operand_select();
    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/decode_pkg.sv
source/op_decoder.sv
source/reg_bank.sv
source/pred_file.sv
source/imm_unit.sv
source/decode_stage.sv
bench/decode_stage_sva.sv
bench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - source/decode_pkg.sv
      - source/op_decoder.sv
      - source/reg_bank.sv
      - source/pred_file.sv
      - source/imm_unit.sv
      - source/decode_stage.sv
  - target: test
    files:
      - bench/decode_stage_sva.sv
      - bench/tb_decode_stage.sv
